//--- logic/ttc_pkg.sv
// --------------------
// Triple timer-counter shared definitions
// Bus types, register layouts, address map and interrupt event bits
// --------------------

package ttc_pkg;

   // Bus types
   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // Address fields
   typedef logic [3:0] reg_kind_t;  // paddr[7:4]
   typedef logic [1:0] chan_idx_t;  // paddr[3:2], 1 to 3 valid

   localparam int NUM_TIMERS = 3;

   // --------------------
   // Register kinds
   localparam reg_kind_t KIND_CLK_CTRL   = 4'd0;
   localparam reg_kind_t KIND_CNTR_CTRL  = 4'd1;
   localparam reg_kind_t KIND_COUNTER    = 4'd2;  // Read only
   localparam reg_kind_t KIND_INTERVAL   = 4'd3;
   localparam reg_kind_t KIND_MATCH1     = 4'd4;
   localparam reg_kind_t KIND_MATCH2     = 4'd5;
   localparam reg_kind_t KIND_MATCH3     = 4'd6;
   localparam reg_kind_t KIND_IRQ_STATUS = 4'd7;  // Clear on read
   localparam reg_kind_t KIND_IRQ_ENABLE = 4'd8;

   // --------------------
   // Control registers, bit 0 is the last field
   typedef logic [3:0] prescale_t;

   typedef struct packed {
      prescale_t prescale;     // Bits 4:1, divide by 2^(prescale+1)
      logic      prescale_en;  // Bit 0
   } clk_ctrl_t;

   typedef struct packed {
      logic count_reset;    // Bit 4, self clearing
      logic match_en;       // Bit 3
      logic decrement;      // Bit 2, count down
      logic interval_mode;  // Bit 1
      logic cnt_disable;    // Bit 0, stops the counter, set by reset
   } cntr_ctrl_t;

   // --------------------
   // Interrupt event vector
   typedef logic [4:0] irq_vec_t;

   localparam int IRQ_INTERVAL = 0;
   localparam int IRQ_MATCH1   = 1;
   localparam int IRQ_MATCH2   = 2;
   localparam int IRQ_MATCH3   = 3;
   localparam int IRQ_OVERFLOW = 4;

   // One decoded write access
   typedef struct packed {
      reg_kind_t kind;
      chan_idx_t chan;
      apb_data_t data;
   } bus_wr_t;

   // Address splitting
   function automatic reg_kind_t addr_kind(input apb_addr_t addr);
      return addr[7:4];
   endfunction

   function automatic chan_idx_t addr_chan(input apb_addr_t addr);
      return addr[3:2];
   endfunction

endpackage

//--- logic/ttc_apb_decode.sv
// --------------------
// APB register decoder for the triple timer-counter
// Turns access phases into write strobes and status clear pulses
// --------------------

`timescale 1ns/1ps

module ttc_apb_decode (
   input  logic               pclk,
   input  logic               rst,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  ttc_pkg::apb_addr_t paddr,
   input  ttc_pkg::apb_data_t pwdata,
   output ttc_pkg::bus_wr_t   wr,
   output logic               wr_en,
   output logic [3:1]         clear_irq
);

   logic access;     // Access phase, completes on this edge
   logic kind_wr;    // Kind accepts writes
   logic chan_ok;    // Channel 1 to 3

   // --------------------
   // Address split
   assign wr = '{
      kind: ttc_pkg::addr_kind(paddr),
      chan: ttc_pkg::addr_chan(paddr),
      data: pwdata
   };

   assign access  = psel & penable;  // No wait states
   assign chan_ok = (wr.chan != '0);

   // Writable kinds, counter and status are read only
   always_comb begin
      case (wr.kind)
         ttc_pkg::KIND_CLK_CTRL,
         ttc_pkg::KIND_CNTR_CTRL,
         ttc_pkg::KIND_INTERVAL,
         ttc_pkg::KIND_MATCH1,
         ttc_pkg::KIND_MATCH2,
         ttc_pkg::KIND_MATCH3,
         ttc_pkg::KIND_IRQ_ENABLE: kind_wr = 1'b1;
         default:                  kind_wr = 1'b0;
      endcase
   end

   assign wr_en = access & pwrite & kind_wr & chan_ok;

   // --------------------
   // Status read clears, one line per channel
   for (genvar n = 1; n <= ttc_pkg::NUM_TIMERS; n++) begin : g_clr
      assign clear_irq[n] = access & ~pwrite
                          & (wr.kind == ttc_pkg::KIND_IRQ_STATUS)
                          & (wr.chan == n);
   end

   // Read and write strobes come from one bus access
   a_wr_xor_clear : assert property (
      @(posedge pclk) disable iff (rst)
      !(wr_en && (|clear_irq))
   ) else $error("wr_en and clear_irq high together");

endmodule

//--- logic/ttc_timer_channel.sv
// --------------------
// One timer-counter channel
// Control and compare registers, prescaler, counter, event flags
// --------------------

`timescale 1ns/1ps

module ttc_timer_channel #(
   parameter int unsigned CNT_WIDTH = 16,
   parameter int unsigned CHAN      = 1
) (
   input  logic                 pclk,
   input  logic                 rst,
   input  ttc_pkg::bus_wr_t     wr,
   input  logic                 wr_en,
   output ttc_pkg::clk_ctrl_t   clk_ctrl,
   output ttc_pkg::cntr_ctrl_t  cntr_ctrl,
   output logic [CNT_WIDTH-1:0] counter,
   output logic [CNT_WIDTH-1:0] interval,
   output logic [CNT_WIDTH-1:0] match1,
   output logic [CNT_WIDTH-1:0] match2,
   output logic [CNT_WIDTH-1:0] match3,
   output ttc_pkg::irq_vec_t    events
);

   localparam int CLK_W  = $bits(ttc_pkg::clk_ctrl_t);
   localparam int CNTR_W = $bits(ttc_pkg::cntr_ctrl_t);

   logic                 sel;          // Write aimed at this channel
   logic                 wr_clk;
   logic                 wr_cntr;
   logic [15:0]          ps_cnt;       // Prescaler
   logic [15:0]          ps_top;       // Last prescaler value
   logic                 ps_wrap;
   logic                 tick;         // Counter step this cycle
   logic [CNT_WIDTH-1:0] cnt_next;
   ttc_pkg::irq_vec_t    flags;

   assign sel     = wr_en && (wr.chan == ttc_pkg::chan_idx_t'(CHAN));
   assign wr_clk  = sel && (wr.kind == ttc_pkg::KIND_CLK_CTRL);
   assign wr_cntr = sel && (wr.kind == ttc_pkg::KIND_CNTR_CTRL);

   // --------------------
   // Register file
   always_ff @(posedge pclk) begin
      if (rst) begin
         clk_ctrl  <= '0;
         cntr_ctrl <= '{cnt_disable: 1'b1, default: 1'b0};  // Stopped
         interval  <= '0;
         match1    <= '0;
         match2    <= '0;
         match3    <= '0;
      end else begin
         if (wr_clk)
            clk_ctrl <= ttc_pkg::clk_ctrl_t'(wr.data[CLK_W-1:0]);
         if (wr_cntr)
            cntr_ctrl <= ttc_pkg::cntr_ctrl_t'(wr.data[CNTR_W-1:0]);
         else
            cntr_ctrl.count_reset <= 1'b0;  // Held one cycle only
         if (sel && wr.kind == ttc_pkg::KIND_INTERVAL) interval <= wr.data[CNT_WIDTH-1:0];
         if (sel && wr.kind == ttc_pkg::KIND_MATCH1)   match1   <= wr.data[CNT_WIDTH-1:0];
         if (sel && wr.kind == ttc_pkg::KIND_MATCH2)   match2   <= wr.data[CNT_WIDTH-1:0];
         if (sel && wr.kind == ttc_pkg::KIND_MATCH3)   match3   <= wr.data[CNT_WIDTH-1:0];
      end
   end

   // --------------------
   // Prescaler, wraps every 2^(prescale+1) cycles
   assign ps_top  = 16'((32'd2 << clk_ctrl.prescale) - 32'd1);
   assign ps_wrap = (ps_cnt == ps_top);

   always_ff @(posedge pclk) begin
      if (rst) begin
         ps_cnt <= '0;
      end else if (wr_clk || cntr_ctrl.count_reset || !clk_ctrl.prescale_en) begin
         ps_cnt <= '0;  // Restart
      end else if (ps_wrap) begin
         ps_cnt <= '0;
      end else begin
         ps_cnt <= ps_cnt + 16'd1;
      end
   end

   assign tick = (!clk_ctrl.prescale_en || ps_wrap)
               && !cntr_ctrl.cnt_disable && !cntr_ctrl.count_reset;

   // --------------------
   // Next count and wrap flags
   always_comb begin
      cnt_next = counter;
      flags    = '0;
      if (cntr_ctrl.interval_mode) begin
         if (cntr_ctrl.decrement) begin
            if (counter == '0) begin
               cnt_next                    = interval;  // Reload
               flags[ttc_pkg::IRQ_INTERVAL] = 1'b1;
            end else begin
               cnt_next = counter - 1'b1;
            end
         end else if (counter >= interval) begin
            cnt_next                    = '0;
            flags[ttc_pkg::IRQ_INTERVAL] = 1'b1;
         end else begin
            cnt_next = counter + 1'b1;
         end
      end else begin
         // Free running, wraps at either end
         cnt_next = cntr_ctrl.decrement ? counter - 1'b1 : counter + 1'b1;
         flags[ttc_pkg::IRQ_OVERFLOW] = cntr_ctrl.decrement ? (counter == '0)
                                                           : (counter == '1);
      end
      // Compare against the new value
      flags[ttc_pkg::IRQ_MATCH1] = cntr_ctrl.match_en && (cnt_next == match1);
      flags[ttc_pkg::IRQ_MATCH2] = cntr_ctrl.match_en && (cnt_next == match2);
      flags[ttc_pkg::IRQ_MATCH3] = cntr_ctrl.match_en && (cnt_next == match3);
   end

   always_ff @(posedge pclk) begin
      if (rst) begin
         counter <= '0;
         events  <= '0;
      end else begin
         if (cntr_ctrl.count_reset) counter <= '0;
         else if (tick)             counter <= cnt_next;
         events <= tick ? flags : '0;  // One cycle pulses
      end
   end

   // --------------------
   // Checks
   a_events_after_tick : assert property (
      @(posedge pclk) disable iff (rst)
      (|events) |-> $past(tick)
   ) else $error("chan %0d events without tick", CHAN);

   a_count_reset_pulse : assert property (
      @(posedge pclk) disable iff (rst)
      cntr_ctrl.count_reset |=> !cntr_ctrl.count_reset
   ) else $error("chan %0d count_reset held", CHAN);

endmodule

//--- logic/ttc_irq_readback.sv
// --------------------
// Interrupt status, enables and read-back mux
// Status is sticky until a status read, set beats clear
// --------------------

`timescale 1ns/1ps

module ttc_irq_readback #(
   parameter int unsigned CNT_WIDTH = 16
) (
   input  logic                 pclk,
   input  logic                 rst,
   input  logic                 psel,
   input  ttc_pkg::apb_addr_t   paddr,
   input  ttc_pkg::bus_wr_t     wr,
   input  logic                 wr_en,
   input  logic [3:1]           clear_irq,
   input  ttc_pkg::irq_vec_t    events1,
   input  ttc_pkg::irq_vec_t    events2,
   input  ttc_pkg::irq_vec_t    events3,
   input  ttc_pkg::clk_ctrl_t   clk_ctrl  [1:ttc_pkg::NUM_TIMERS],
   input  ttc_pkg::cntr_ctrl_t  cntr_ctrl [1:ttc_pkg::NUM_TIMERS],
   input  logic [CNT_WIDTH-1:0] counter   [1:ttc_pkg::NUM_TIMERS],
   input  logic [CNT_WIDTH-1:0] interval  [1:ttc_pkg::NUM_TIMERS],
   input  logic [CNT_WIDTH-1:0] match1    [1:ttc_pkg::NUM_TIMERS],
   input  logic [CNT_WIDTH-1:0] match2    [1:ttc_pkg::NUM_TIMERS],
   input  logic [CNT_WIDTH-1:0] match3    [1:ttc_pkg::NUM_TIMERS],
   output ttc_pkg::apb_data_t   prdata,
   output logic [3:1]           interrupt
);

   ttc_pkg::irq_vec_t events     [1:ttc_pkg::NUM_TIMERS];
   ttc_pkg::irq_vec_t irq_status [1:ttc_pkg::NUM_TIMERS];
   ttc_pkg::irq_vec_t irq_enable [1:ttc_pkg::NUM_TIMERS];

   assign events[1] = events1;
   assign events[2] = events2;
   assign events[3] = events3;

   // --------------------
   // Per channel status and enable
   for (genvar n = 1; n <= ttc_pkg::NUM_TIMERS; n++) begin : g_irq
      always_ff @(posedge pclk) begin
         if (rst) begin
            irq_status[n] <= '0;
            irq_enable[n] <= '0;
         end else begin
            if (wr_en && wr.kind == ttc_pkg::KIND_IRQ_ENABLE && wr.chan == n)
               irq_enable[n] <= wr.data[$bits(ttc_pkg::irq_vec_t)-1:0];
            // New events survive a read in the same cycle
            irq_status[n] <= (clear_irq[n] ? '0 : irq_status[n]) | events[n];
         end
      end

      assign interrupt[n] = |(irq_status[n] & irq_enable[n]);

      a_irq_masked : assert property (
         @(posedge pclk) disable iff (rst)
         (irq_enable[n] == '0) |-> !interrupt[n]
      ) else $error("interrupt %0d with enable clear", n);
   end

   // --------------------
   // Read mux, zero extended
   always_comb begin
      ttc_pkg::chan_idx_t  ch;
      ttc_pkg::cntr_ctrl_t ctrl_rd;
      ch      = ttc_pkg::addr_chan(paddr);
      ctrl_rd = '0;
      prdata  = '0;
      if (psel && ch != '0) begin
         ctrl_rd             = cntr_ctrl[ch];
         ctrl_rd.count_reset = 1'b0;  // Always reads 0
         case (ttc_pkg::addr_kind(paddr))
            ttc_pkg::KIND_CLK_CTRL:   prdata = ttc_pkg::apb_data_t'(clk_ctrl[ch]);
            ttc_pkg::KIND_CNTR_CTRL:  prdata = ttc_pkg::apb_data_t'(ctrl_rd);
            ttc_pkg::KIND_COUNTER:    prdata = ttc_pkg::apb_data_t'(counter[ch]);
            ttc_pkg::KIND_INTERVAL:   prdata = ttc_pkg::apb_data_t'(interval[ch]);
            ttc_pkg::KIND_MATCH1:     prdata = ttc_pkg::apb_data_t'(match1[ch]);
            ttc_pkg::KIND_MATCH2:     prdata = ttc_pkg::apb_data_t'(match2[ch]);
            ttc_pkg::KIND_MATCH3:     prdata = ttc_pkg::apb_data_t'(match3[ch]);
            ttc_pkg::KIND_IRQ_STATUS: prdata = ttc_pkg::apb_data_t'(irq_status[ch]);
            ttc_pkg::KIND_IRQ_ENABLE: prdata = ttc_pkg::apb_data_t'(irq_enable[ch]);
            default:                  prdata = '0;  // Unmapped
         endcase
      end
   end

endmodule

//--- logic/ttc_top.sv
// --------------------
// Triple timer-counter top level
// APB decoder, three timer channels, interrupt and read-back block
// --------------------

`timescale 1ns/1ps

module ttc_top #(
   parameter int unsigned CNT_WIDTH = 16
) (
   input  logic               pclk,
   input  logic               rst,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  ttc_pkg::apb_addr_t paddr,
   input  ttc_pkg::apb_data_t pwdata,
   output ttc_pkg::apb_data_t prdata,
   output logic [3:1]         interrupt
);

   // --------------------
   // Interconnect
   ttc_pkg::bus_wr_t     wr;
   logic                 wr_en;
   logic [3:1]           clear_irq;
   ttc_pkg::irq_vec_t    events    [1:ttc_pkg::NUM_TIMERS];
   ttc_pkg::clk_ctrl_t   clk_ctrl  [1:ttc_pkg::NUM_TIMERS];
   ttc_pkg::cntr_ctrl_t  cntr_ctrl [1:ttc_pkg::NUM_TIMERS];
   logic [CNT_WIDTH-1:0] counter   [1:ttc_pkg::NUM_TIMERS];
   logic [CNT_WIDTH-1:0] interval  [1:ttc_pkg::NUM_TIMERS];
   logic [CNT_WIDTH-1:0] match1    [1:ttc_pkg::NUM_TIMERS];
   logic [CNT_WIDTH-1:0] match2    [1:ttc_pkg::NUM_TIMERS];
   logic [CNT_WIDTH-1:0] match3    [1:ttc_pkg::NUM_TIMERS];

   ttc_apb_decode decode_i (
      .pclk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
      .wr, .wr_en, .clear_irq
   );

   // --------------------
   // Timer channels 1 to 3
   ttc_timer_channel #(.CNT_WIDTH(CNT_WIDTH), .CHAN(1)) chan1_i (
      .pclk, .rst, .wr, .wr_en,
      .clk_ctrl(clk_ctrl[1]), .cntr_ctrl(cntr_ctrl[1]), .counter(counter[1]),
      .interval(interval[1]), .match1(match1[1]), .match2(match2[1]),
      .match3(match3[1]), .events(events[1])
   );

   ttc_timer_channel #(.CNT_WIDTH(CNT_WIDTH), .CHAN(2)) chan2_i (
      .pclk, .rst, .wr, .wr_en,
      .clk_ctrl(clk_ctrl[2]), .cntr_ctrl(cntr_ctrl[2]), .counter(counter[2]),
      .interval(interval[2]), .match1(match1[2]), .match2(match2[2]),
      .match3(match3[2]), .events(events[2])
   );

   ttc_timer_channel #(.CNT_WIDTH(CNT_WIDTH), .CHAN(3)) chan3_i (
      .pclk, .rst, .wr, .wr_en,
      .clk_ctrl(clk_ctrl[3]), .cntr_ctrl(cntr_ctrl[3]), .counter(counter[3]),
      .interval(interval[3]), .match1(match1[3]), .match2(match2[3]),
      .match3(match3[3]), .events(events[3])
   );

   ttc_irq_readback #(.CNT_WIDTH(CNT_WIDTH)) readback_i (
      .pclk, .rst, .psel, .paddr, .wr, .wr_en, .clear_irq,
      .events1(events[1]), .events2(events[2]), .events3(events[3]),
      .clk_ctrl, .cntr_ctrl, .counter, .interval, .match1, .match2, .match3,
      .prdata, .interrupt
   );

endmodule

//--- dv/ttc_checker.sv
// --------------------
// Reference model and checker for the triple timer-counter
// Rebuilds registers, prescalers and counters from bus traffic
// Compares prdata in access phases and interrupt lines every cycle
// --------------------

`timescale 1ns/1ps

module ttc_checker #(
   parameter int unsigned CNT_WIDTH = 16
) (
   input  logic               pclk,
   input  logic               rst,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  ttc_pkg::apb_addr_t paddr,
   input  ttc_pkg::apb_data_t pwdata,
   input  ttc_pkg::apb_data_t prdata,
   input  logic [3:1]         interrupt,
   output int                 checks,
   output int                 errors
);

   localparam int NT = ttc_pkg::NUM_TIMERS;

   typedef logic [CNT_WIDTH-1:0] cnt_t;

   // --------------------
   // Model state, one entry per channel
   logic               pre_en    [1:NT];
   ttc_pkg::prescale_t pre_exp   [1:NT];
   int unsigned        pre_cnt   [1:NT];  // Prescaler position
   logic               stop      [1:NT];
   logic               intv_mode [1:NT];
   logic               down      [1:NT];
   logic               match_on  [1:NT];
   logic               zero_req  [1:NT];  // count_reset pending
   cnt_t               count     [1:NT];
   cnt_t               intv      [1:NT];
   cnt_t               cmp       [1:NT][1:3];
   ttc_pkg::irq_vec_t  evt       [1:NT];  // Flags from the last tick
   ttc_pkg::irq_vec_t  stat      [1:NT];
   ttc_pkg::irq_vec_t  ena       [1:NT];
   logic               valid = 1'b0;     // Set once reset is seen

   initial begin
      checks = 0;
      errors = 0;
   end

   task automatic reset_model();
      for (int n = 1; n <= NT; n++) begin
         pre_en[n]    = 1'b0;
         pre_exp[n]   = '0;
         pre_cnt[n]   = 0;
         stop[n]      = 1'b1;  // Counters come up stopped
         intv_mode[n] = 1'b0;
         down[n]      = 1'b0;
         match_on[n]  = 1'b0;
         zero_req[n]  = 1'b0;
         count[n]     = '0;
         intv[n]      = '0;
         for (int m = 1; m <= 3; m++)
            cmp[n][m] = '0;
         evt[n]  = '0;
         stat[n] = '0;
         ena[n]  = '0;
      end
   endtask

   // Register value seen on the bus for one address
   function automatic ttc_pkg::apb_data_t expected_read(input ttc_pkg::apb_addr_t addr);
      ttc_pkg::reg_kind_t k;
      int c;
      k = addr[7:4];
      c = addr[3:2];
      if (c == 0)
         return '0;
      case (k)
         ttc_pkg::KIND_CLK_CTRL:   return {27'd0, pre_exp[c], pre_en[c]};
         ttc_pkg::KIND_CNTR_CTRL:  return {28'd0, match_on[c], down[c], intv_mode[c], stop[c]};
         ttc_pkg::KIND_COUNTER:    return 32'(count[c]);
         ttc_pkg::KIND_INTERVAL:   return 32'(intv[c]);
         ttc_pkg::KIND_MATCH1:     return 32'(cmp[c][1]);
         ttc_pkg::KIND_MATCH2:     return 32'(cmp[c][2]);
         ttc_pkg::KIND_MATCH3:     return 32'(cmp[c][3]);
         ttc_pkg::KIND_IRQ_STATUS: return 32'(stat[c]);
         ttc_pkg::KIND_IRQ_ENABLE: return 32'(ena[c]);
         default:                  return '0;
      endcase
   endfunction

   // --------------------
   // Advance the model over one rising edge with the current bus inputs
   task automatic step_model();
      ttc_pkg::reg_kind_t k;
      int                 c;
      int unsigned        period;
      logic               tick;
      logic               here;   // Write aimed at this channel
      cnt_t               nxt;
      ttc_pkg::irq_vec_t  flags;
      k = paddr[7:4];
      c = paddr[3:2];
      for (int n = 1; n <= NT; n++) begin
         period = 2 << pre_exp[n];
         tick   = (!pre_en[n] || pre_cnt[n] == period - 1) && !stop[n] && !zero_req[n];
         nxt    = count[n];
         flags  = '0;
         if (tick) begin
            if (intv_mode[n] && down[n]) begin
               nxt = (count[n] == '0) ? intv[n] : count[n] - 1'b1;
               flags[ttc_pkg::IRQ_INTERVAL] = (count[n] == '0);
            end else if (intv_mode[n]) begin
               nxt = (count[n] >= intv[n]) ? '0 : count[n] + 1'b1;
               flags[ttc_pkg::IRQ_INTERVAL] = (count[n] >= intv[n]);
            end else begin
               nxt = down[n] ? count[n] - 1'b1 : count[n] + 1'b1;
               flags[ttc_pkg::IRQ_OVERFLOW] = down[n] ? (count[n] == '0) : (&count[n]);
            end
            for (int m = 1; m <= 3; m++)
               if (match_on[n] && cmp[n][m] == nxt)
                  flags[ttc_pkg::IRQ_MATCH1 + m - 1] = 1'b1;
         end
         // Set wins over a status read in the same cycle
         if (psel && penable && !pwrite && k == ttc_pkg::KIND_IRQ_STATUS && c == n)
            stat[n] = '0;
         stat[n] = stat[n] | evt[n];
         evt[n]  = flags;
         here    = psel && penable && pwrite && c == n;
         count[n] = zero_req[n] ? '0 : nxt;
         if (zero_req[n] || (here && k == ttc_pkg::KIND_CLK_CTRL))
            pre_cnt[n] = 0;  // Restart
         else if (pre_en[n])
            pre_cnt[n] = (pre_cnt[n] + 1) % period;
         zero_req[n] = 1'b0;
         if (here) begin
            case (k)
               ttc_pkg::KIND_CLK_CTRL: begin
                  pre_en[n]  = pwdata[0];
                  pre_exp[n] = pwdata[4:1];
               end
               ttc_pkg::KIND_CNTR_CTRL: begin
                  stop[n]      = pwdata[0];
                  intv_mode[n] = pwdata[1];
                  down[n]      = pwdata[2];
                  match_on[n]  = pwdata[3];
                  zero_req[n]  = pwdata[4];
               end
               ttc_pkg::KIND_INTERVAL:   intv[n]   = pwdata[CNT_WIDTH-1:0];
               ttc_pkg::KIND_MATCH1:     cmp[n][1] = pwdata[CNT_WIDTH-1:0];
               ttc_pkg::KIND_MATCH2:     cmp[n][2] = pwdata[CNT_WIDTH-1:0];
               ttc_pkg::KIND_MATCH3:     cmp[n][3] = pwdata[CNT_WIDTH-1:0];
               ttc_pkg::KIND_IRQ_ENABLE: ena[n]    = pwdata[4:0];
               default: ;  // Counter, status and unmapped kinds ignore writes
            endcase
         end
      end
   endtask

   task automatic compare_outputs();
      ttc_pkg::apb_data_t exp_rd;
      logic [3:1]         exp_irq;
      for (int n = 1; n <= NT; n++)
         exp_irq[n] = |(stat[n] & ena[n]);
      checks++;
      if (interrupt !== exp_irq) begin
         errors++;
         $display("Error: interrupt expected %h actual %h at %0t", exp_irq, interrupt, $time);
      end
      if (psel && penable) begin
         exp_rd = expected_read(paddr);
         checks++;
         if (prdata !== exp_rd) begin
            errors++;
            $display("Error: prdata addr %h expected %h actual %h at %0t",
                     paddr, exp_rd, prdata, $time);
         end
      end
   endtask

   // Outputs settle mid cycle, inputs hold until after the next edge
   always @(negedge pclk) begin
      if (rst) begin
         reset_model();
         valid = 1'b1;
      end else if (valid) begin
         compare_outputs();
         step_model();
      end
   end

endmodule

//--- dv/ttc_tb.sv
// --------------------
// Testbench for the triple timer-counter
// Clock, reset, watchdog, LFSR driven APB traffic, DUT and checker
// --------------------

`timescale 1ns/1ps

module ttc_tb;

   localparam int unsigned CNT_WIDTH = 16;
   localparam int CLK_PERIOD   = 100;  // ns
   localparam int RESET_CYCLES = 4;
   localparam int REG_OPS   = 120;
   localparam int RUN_OPS   = 60;
   localparam int INTV_OPS  = 80;
   localparam int MATCH_OPS = 80;
   localparam int IRQ_OPS   = 100;
   localparam int SETUP_OPS = 80;  // Bound on configuration writes
   localparam int TOTAL_OPS = REG_OPS + 4 * RUN_OPS + 2 * INTV_OPS + 2 * MATCH_OPS
                            + IRQ_OPS + SETUP_OPS;
   // At most two cycles per op, then doubled
   localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + 2 * TOTAL_OPS);

   logic               pclk;
   logic               rst;
   logic               psel;
   logic               penable;
   logic               pwrite;
   ttc_pkg::apb_addr_t paddr;
   ttc_pkg::apb_data_t pwdata;
   ttc_pkg::apb_data_t prdata;
   logic [3:1]         interrupt;
   int                 checks;
   int                 errors;
   int                 test_no = 0;
   logic [31:0]        lfsr;

   ttc_top #(.CNT_WIDTH(CNT_WIDTH)) dut_i (
      .pclk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .interrupt
   );

   ttc_checker #(.CNT_WIDTH(CNT_WIDTH)) checker_i (
      .pclk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .interrupt,
      .checks, .errors
   );

   initial begin
      pclk = 1'b0;
      forever #(CLK_PERIOD / 2) pclk = ~pclk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   // --------------------
   // Galois LFSR, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      end
      return v;
   endfunction

   function automatic ttc_pkg::chan_idx_t rand_chan();
      ttc_pkg::chan_idx_t c;
      c = rand_bits(2);
      return (c == 2'd0) ? 2'd1 : c;
   endfunction

   function automatic ttc_pkg::apb_addr_t reg_addr(input ttc_pkg::reg_kind_t kind,
                                                   input ttc_pkg::chan_idx_t chan);
      return {kind, chan, 2'b00};
   endfunction

   function automatic ttc_pkg::apb_data_t clk_word(input logic en, input ttc_pkg::prescale_t ex);
      ttc_pkg::clk_ctrl_t k;
      k = '{prescale: ex, prescale_en: en};
      return {27'd0, k};
   endfunction

   // Counter always enabled here
   function automatic ttc_pkg::apb_data_t ctrl_word(input logic imode, input logic dec,
                                                    input logic men, input logic crst);
      ttc_pkg::cntr_ctrl_t k;
      k = '{count_reset: crst, match_en: men, decrement: dec, interval_mode: imode,
            cnt_disable: 1'b0};
      return {27'd0, k};
   endfunction

   // --------------------
   // Bus tasks, inputs change 5 ns after the edge
   task automatic next_cycle();
      @(posedge pclk);
      #5;
   endtask

   task automatic bus_access(input logic write, input ttc_pkg::apb_addr_t addr,
                             input ttc_pkg::apb_data_t data);
      psel    = 1'b1;  // Setup
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = data;
      next_cycle();
      penable = 1'b1;  // Access
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic setup_chan(input ttc_pkg::chan_idx_t c, input ttc_pkg::apb_data_t clk,
                             input ttc_pkg::apb_data_t ctrl, input ttc_pkg::apb_data_t intv);
      bus_access(1'b1, reg_addr(ttc_pkg::KIND_CLK_CTRL, c), clk);
      bus_access(1'b1, reg_addr(ttc_pkg::KIND_INTERVAL, c), intv);
      bus_access(1'b1, reg_addr(ttc_pkg::KIND_CNTR_CTRL, c), ctrl);
   endtask

   // Idle cycles mixed with counter and status reads
   task automatic mixed_ops(input int n);
      for (int i = 0; i < n; i++) begin
         case (rand_bits(2))
            0, 1:    next_cycle();
            2:       bus_access(1'b0, reg_addr(ttc_pkg::KIND_COUNTER, rand_chan()), '0);
            default: bus_access(1'b0, reg_addr(ttc_pkg::KIND_IRQ_STATUS, rand_chan()), '0);
         endcase
      end
   endtask

   task automatic report_test(input string name);
      test_no++;
      $display("Test %0d %s done: %0d checks, %0d errors so far", test_no, name, checks, errors);
   endtask

   // --------------------
   // Tests
   task automatic test_register_access();
      ttc_pkg::reg_kind_t kind;
      ttc_pkg::chan_idx_t chan;
      for (int i = 0; i < REG_OPS; i++) begin
         kind = ttc_pkg::reg_kind_t'(rand_bits(4) % 9);
         chan = rand_bits(2);  // Channel 0 included
         case (rand_bits(2))
            0:       bus_access(1'b1, reg_addr(kind, chan), rand_bits(32));
            1:       bus_access(1'b0, reg_addr(kind, chan), '0);
            2:       bus_access(1'b0, ttc_pkg::apb_addr_t'(rand_bits(8)), '0);
            default: bus_access(1'b1, ttc_pkg::apb_addr_t'(rand_bits(8)), rand_bits(32));
         endcase
      end
   endtask

   task automatic test_free_run();
      // Down from zero wraps at once, then back up across the top
      for (int c = 1; c <= 3; c++)
         setup_chan(c, clk_word(1'b0, '0), ctrl_word(1'b0, 1'b1, 1'b0, 1'b1), '0);
      mixed_ops(RUN_OPS);
      for (int c = 1; c <= 3; c++)
         bus_access(1'b1, reg_addr(ttc_pkg::KIND_CNTR_CTRL, c), ctrl_word(0, 0, 0, 0));
      mixed_ops(2 * RUN_OPS);
      for (int c = 1; c <= 3; c++)
         setup_chan(c, clk_word(1'b1, rand_bits(2)), ctrl_word(0, rand_bits(1), 0, 1), '0);
      mixed_ops(RUN_OPS);
   endtask

   task automatic test_interval();
      for (int r = 0; r < 2; r++) begin
         for (int c = 1; c <= 3; c++)
            setup_chan(c, clk_word(1'b0, '0), ctrl_word(1, rand_bits(1), 0, 1), rand_bits(4) + 1);
         mixed_ops(INTV_OPS);
      end
   endtask

   task automatic test_match();
      for (int c = 1; c <= 3; c++) begin
         for (int m = 0; m < 3; m++)
            bus_access(1'b1, reg_addr(ttc_pkg::reg_kind_t'(ttc_pkg::KIND_MATCH1 + m), c),
                       rand_bits(4));
         setup_chan(c, clk_word(1'b0, '0), ctrl_word(1, rand_bits(1), 1, 1), 32'd15);
      end
      mixed_ops(MATCH_OPS);
      for (int c = 1; c <= 3; c++)  // Matches off
         bus_access(1'b1, reg_addr(ttc_pkg::KIND_CNTR_CTRL, c), ctrl_word(1, 0, 0, 0));
      mixed_ops(MATCH_OPS);
   endtask

   task automatic test_interrupts();
      for (int c = 1; c <= 3; c++) begin
         bus_access(1'b1, reg_addr(ttc_pkg::KIND_IRQ_ENABLE, c), rand_bits(5));
         setup_chan(c, clk_word(1'b0, '0), ctrl_word(1, rand_bits(1), 1, 1), rand_bits(3) + 2);
      end
      mixed_ops(IRQ_OPS);
   endtask

   // --------------------
   initial begin
      lfsr    = 32'hb225a13e;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (RESET_CYCLES) @(posedge pclk);
      #5;
      rst = 1'b0;
      test_register_access();
      report_test("register access");
      test_free_run();
      report_test("free-running count");
      test_interval();
      report_test("interval mode");
      test_match();
      report_test("match events");
      test_interrupts();
      report_test("interrupts");
      $display("Tests %0d, checks %0d, errors %0d", test_no, checks, errors);
      if (errors == 0 && checks > 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- all.f
logic/ttc_pkg.sv
logic/ttc_apb_decode.sv
logic/ttc_timer_channel.sv
logic/ttc_irq_readback.sv
logic/ttc_top.sv
dv/ttc_checker.sv
dv/ttc_tb.sv

//--- Bender.yml
package:
  name: ttc

sources:
  # RTL
  - logic/ttc_pkg.sv
  - logic/ttc_apb_decode.sv
  - logic/ttc_timer_channel.sv
  - logic/ttc_irq_readback.sv
  - logic/ttc_top.sv
  # Testbench
  - target: test
    files:
      - dv/ttc_checker.sv
      - dv/ttc_tb.sv
